// File: hdl/ao_periph_pkg.sv
// Always-on peripheral subsystem package
// Bus structs, address map, register offsets and boot ROM image

package ao_periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
    logic        ready;
  } reg_rsp_t;

  // Address map, one 4 KiB window per peer
  localparam int unsigned AO_PERIPHERALS    = 4;
  localparam int unsigned PORT_SEL_WIDTH    = 2;
  localparam int unsigned SOC_CTRL_IDX      = 0;
  localparam int unsigned BOOTROM_IDX       = 1;
  localparam int unsigned RV_TIMER_IDX      = 2;
  localparam int unsigned POWER_MANAGER_IDX = 3;
  localparam logic [31:0] AO_BASE_ADDR      = 32'h2000_0000;

  localparam logic [11:0] SOC_CTRL_EXIT_VALID  = 12'h000;
  localparam logic [11:0] SOC_CTRL_EXIT_VALUE  = 12'h004;
  localparam logic [11:0] SOC_CTRL_BOOT_SELECT = 12'h008;
  localparam logic [11:0] SOC_CTRL_EXEC_FLASH  = 12'h00C;

  localparam logic [11:0] TIMER_CTRL     = 12'h000;
  localparam logic [11:0] TIMER_MTIME    = 12'h004;
  localparam logic [11:0] TIMER_MTIMECMP = 12'h008;

  localparam logic [11:0] PM_CTRL    = 12'h000;
  localparam logic [11:0] PM_WAKE_EN = 12'h004;
  localparam logic [11:0] PM_STATUS  = 12'h008;

  localparam int unsigned BOOT_ROM_WORDS = 16;
  localparam logic [31:0] BOOT_ROM_DATA [BOOT_ROM_WORDS] = '{
    32'h0000_0297, 32'h0402_8293, 32'h3052_9073, 32'h2000_0337,
    32'h0083_2383, 32'h0003_8663, 32'h1000_0437, 32'h0004_0067,
    32'h0000_0417, 32'h0004_2483, 32'h0004_8067, 32'h1050_0073,
    32'hffdf_f06f, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013
  };

  // Byte-lane merge for strobed register writes
  function automatic logic [31:0] apply_wstrb(logic [31:0] old_q, logic [31:0] wdata,
                                              logic [3:0] wstrb);
    logic [31:0] merged;
    merged = old_q;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage : ao_periph_pkg

// File: hdl/obi_reg_bridge.sv
// OBI slave to register bus bridge
// Decodes the peer window and returns a one-cycle pipelined response

module obi_reg_bridge (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  ao_periph_pkg::obi_req_t                                  obi_req_i,
  output ao_periph_pkg::obi_resp_t                                 obi_resp_o,
  output ao_periph_pkg::reg_req_t [ao_periph_pkg::AO_PERIPHERALS-1:0] reg_req_o,
  input  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::AO_PERIPHERALS-1:0] reg_rsp_i
);

  logic                                     mapped;
  logic [ao_periph_pkg::PORT_SEL_WIDTH-1:0] sel;
  ao_periph_pkg::reg_rsp_t                  sel_rsp;
  logic                                     err_d;
  logic [31:0]                              rdata_d;

  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  // Upper address bits must hit the always-on base
  assign mapped  = obi_req_i.addr[31:14] == ao_periph_pkg::AO_BASE_ADDR[31:14];
  assign sel     = obi_req_i.addr[12 +: ao_periph_pkg::PORT_SEL_WIDTH];
  assign sel_rsp = reg_rsp_i[sel];

  always_comb begin
    for (int i = 0; i < ao_periph_pkg::AO_PERIPHERALS; i++) begin
      reg_req_o[i].valid = obi_req_i.req && mapped &&
                           (sel == ao_periph_pkg::PORT_SEL_WIDTH'(i));
      reg_req_o[i].write = obi_req_i.we;
      reg_req_o[i].addr  = obi_req_i.addr;
      reg_req_o[i].wdata = obi_req_i.wdata;
      reg_req_o[i].wstrb = obi_req_i.be;
    end
  end

  // A peer that is not ready is treated as a failed access
  assign err_d   = !mapped || sel_rsp.error || !sel_rsp.ready;
  assign rdata_d = (obi_req_i.we || err_d) ? 32'h0 : sel_rsp.rdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
      if (obi_req_i.req) begin
        err_q <= err_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  always_comb begin
    obi_resp_o.gnt    = obi_req_i.req;
    obi_resp_o.rvalid = rvalid_q;
    obi_resp_o.err    = err_q;
    obi_resp_o.rdata  = rdata_q;
  end

endmodule : obi_reg_bridge

// File: hdl/soc_ctrl.sv
// SoC control registers
// Exit flag and value for the host, boot strap readback

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    boot_select_i,
  input  logic                    execute_from_flash_i,
  output logic                    exit_valid_o,
  output logic [31:0]             exit_value_o
);

  logic [11:0] offset;
  logic        wr_en;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic        boot_select_q;
  logic        exec_flash_q;

  assign offset = reg_req_i.addr[11:0];
  assign wr_en  = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_q  <= 1'b0;
      exit_value_q  <= 32'h0;
      boot_select_q <= 1'b0;
      exec_flash_q  <= 1'b0;
    end else begin
      // Strap pins are sampled every cycle
      boot_select_q <= boot_select_i;
      exec_flash_q  <= execute_from_flash_i;
      if (wr_en && offset == ao_periph_pkg::SOC_CTRL_EXIT_VALID && reg_req_i.wstrb[0]) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (wr_en && offset == ao_periph_pkg::SOC_CTRL_EXIT_VALUE) begin
        exit_value_q <= ao_periph_pkg::apply_wstrb(exit_value_q, reg_req_i.wdata,
                                                   reg_req_i.wstrb);
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.ready = 1'b1;
    if (reg_req_i.valid) begin
      case (offset)
        ao_periph_pkg::SOC_CTRL_EXIT_VALID:  reg_rsp_o.rdata = {31'h0, exit_valid_q};
        ao_periph_pkg::SOC_CTRL_EXIT_VALUE:  reg_rsp_o.rdata = exit_value_q;
        ao_periph_pkg::SOC_CTRL_BOOT_SELECT: reg_rsp_o.rdata = {31'h0, boot_select_q};
        ao_periph_pkg::SOC_CTRL_EXEC_FLASH:  reg_rsp_o.rdata = {31'h0, exec_flash_q};
        default:                             reg_rsp_o.error = 1'b1;
      endcase
      // Strap registers are read only
      if (reg_req_i.write && (offset == ao_periph_pkg::SOC_CTRL_BOOT_SELECT ||
                              offset == ao_periph_pkg::SOC_CTRL_EXEC_FLASH)) begin
        reg_rsp_o.error = 1'b1;
      end
      if (reg_rsp_o.error) begin
        reg_rsp_o.rdata = 32'h0;
      end
    end
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

// File: hdl/boot_rom.sv
// Boot ROM
// Combinational word lookup in the first 64 bytes of the window

module boot_rom (
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o
);

  logic       in_range;
  logic [3:0] word_idx;
  logic       bad_access;

  // 16 words cover offsets 0x00 to 0x3C
  assign in_range   = reg_req_i.addr[11:6] == 6'h0;
  assign word_idx   = reg_req_i.addr[5:2];
  assign bad_access = reg_req_i.write || !in_range;

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = 32'h0;
    if (reg_req_i.valid) begin
      if (bad_access) begin
        reg_rsp_o.error = 1'b1;
      end else begin
        reg_rsp_o.rdata = ao_periph_pkg::BOOT_ROM_DATA[word_idx];
      end
    end
  end

endmodule : boot_rom

// File: hdl/rv_timer.sv
// Machine timer
// Free-running mtime with compare and a registered level interrupt

module rv_timer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                    timer_irq_o
);

  logic [11:0] offset;
  logic        wr_en;
  logic        enable_q;
  logic [31:0] mtime_q;
  logic [31:0] mtimecmp_q;
  logic        irq_q;

  assign offset = reg_req_i.addr[11:0];
  assign wr_en  = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q   <= 1'b0;
      mtime_q    <= 32'h0;
      mtimecmp_q <= 32'h0;
      irq_q      <= 1'b0;
    end else begin
      if (wr_en && offset == ao_periph_pkg::TIMER_CTRL && reg_req_i.wstrb[0]) begin
        enable_q <= reg_req_i.wdata[0];
      end
      // Software write wins over the count
      if (wr_en && offset == ao_periph_pkg::TIMER_MTIME) begin
        mtime_q <= ao_periph_pkg::apply_wstrb(mtime_q, reg_req_i.wdata, reg_req_i.wstrb);
      end else if (enable_q) begin
        mtime_q <= mtime_q + 32'h1;
      end
      if (wr_en && offset == ao_periph_pkg::TIMER_MTIMECMP) begin
        mtimecmp_q <= ao_periph_pkg::apply_wstrb(mtimecmp_q, reg_req_i.wdata,
                                                 reg_req_i.wstrb);
      end
      irq_q <= enable_q && (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.ready = 1'b1;
    if (reg_req_i.valid) begin
      case (offset)
        ao_periph_pkg::TIMER_CTRL:     reg_rsp_o.rdata = {31'h0, enable_q};
        ao_periph_pkg::TIMER_MTIME:    reg_rsp_o.rdata = mtime_q;
        ao_periph_pkg::TIMER_MTIMECMP: reg_rsp_o.rdata = mtimecmp_q;
        default:                       reg_rsp_o.error = 1'b1;
      endcase
    end
  end

  assign timer_irq_o = irq_q;

endmodule : rv_timer

// File: hdl/power_manager.sv
// CPU subsystem power manager
// Gates power and holds reset while the core sleeps, wakes on timer

module power_manager (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    timer_irq_i,
  input  logic                    core_sleep_i,
  output logic                    cpu_subsystem_powergate_switch_o,
  output logic                    cpu_subsystem_rst_no
);

  typedef enum logic [2:0] {
    PM_ACTIVE      = 3'd0,
    PM_RST_ASSERT  = 3'd1,
    PM_GATED       = 3'd2,
    PM_UNGATE      = 3'd3,
    PM_RST_RELEASE = 3'd4
  } pm_state_e;

  pm_state_e   state_q;
  pm_state_e   state_d;
  logic [11:0] offset;
  logic        wr_en;
  logic        arm_q;
  logic        wake_en_q;

  assign offset = reg_req_i.addr[11:0];
  assign wr_en  = reg_req_i.valid && reg_req_i.write;

  always_comb begin
    state_d = state_q;
    case (state_q)
      PM_ACTIVE:      if (arm_q && core_sleep_i) state_d = PM_RST_ASSERT;
      PM_RST_ASSERT:  state_d = PM_GATED;
      PM_GATED:       if (wake_en_q && timer_irq_i) state_d = PM_UNGATE;
      PM_UNGATE:      state_d = PM_RST_RELEASE;
      PM_RST_RELEASE: state_d = PM_ACTIVE;
      default:        state_d = PM_ACTIVE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= PM_ACTIVE;
      arm_q     <= 1'b0;
      wake_en_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Arm is one-shot, dropped on the way back to active
      if (state_q == PM_RST_RELEASE) begin
        arm_q <= 1'b0;
      end else if (wr_en && offset == ao_periph_pkg::PM_CTRL && reg_req_i.wstrb[0]) begin
        arm_q <= reg_req_i.wdata[0];
      end
      if (wr_en && offset == ao_periph_pkg::PM_WAKE_EN && reg_req_i.wstrb[0]) begin
        wake_en_q <= reg_req_i.wdata[0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.ready = 1'b1;
    if (reg_req_i.valid) begin
      case (offset)
        ao_periph_pkg::PM_CTRL:    reg_rsp_o.rdata = {31'h0, arm_q};
        ao_periph_pkg::PM_WAKE_EN: reg_rsp_o.rdata = {31'h0, wake_en_q};
        ao_periph_pkg::PM_STATUS:  begin
          if (reg_req_i.write) begin
            reg_rsp_o.error = 1'b1;
          end else begin
            reg_rsp_o.rdata = {29'h0, state_q};
          end
        end
        default:                   reg_rsp_o.error = 1'b1;
      endcase
    end
  end

  assign cpu_subsystem_powergate_switch_o = (state_q == PM_GATED) || (state_q == PM_UNGATE);
  assign cpu_subsystem_rst_no = !((state_q == PM_RST_ASSERT) || (state_q == PM_GATED) ||
                                  (state_q == PM_UNGATE));

endmodule : power_manager

// File: hdl/ao_peripheral_subsystem.sv
// Always-on peripheral subsystem top level
// OBI bridge feeding SoC control, boot ROM, timer and power manager

module ao_peripheral_subsystem (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ao_periph_pkg::obi_req_t  slave_req_i,
  output ao_periph_pkg::obi_resp_t slave_resp_o,
  input  logic                     boot_select_i,
  input  logic                     execute_from_flash_i,
  output logic                     exit_valid_o,
  output logic [31:0]              exit_value_o,
  input  logic                     core_sleep_i,
  output logic                     cpu_subsystem_powergate_switch_o,
  output logic                     cpu_subsystem_rst_no,
  output logic                     rv_timer_irq_timer_o
);

  ao_periph_pkg::reg_req_t [ao_periph_pkg::AO_PERIPHERALS-1:0] periph_req;
  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::AO_PERIPHERALS-1:0] periph_rsp;

  logic timer_irq;

  obi_reg_bridge obi_reg_bridge_i (
    .clk_i,
    .rst_n_i,
    .obi_req_i (slave_req_i),
    .obi_resp_o(slave_resp_o),
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(periph_req[ao_periph_pkg::SOC_CTRL_IDX]),
    .reg_rsp_o(periph_rsp[ao_periph_pkg::SOC_CTRL_IDX]),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  boot_rom boot_rom_i (
    .reg_req_i(periph_req[ao_periph_pkg::BOOTROM_IDX]),
    .reg_rsp_o(periph_rsp[ao_periph_pkg::BOOTROM_IDX])
  );

  rv_timer rv_timer_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i  (periph_req[ao_periph_pkg::RV_TIMER_IDX]),
    .reg_rsp_o  (periph_rsp[ao_periph_pkg::RV_TIMER_IDX]),
    .timer_irq_o(timer_irq)
  );

  // Timer interrupt also wakes the gated CPU subsystem
  power_manager power_manager_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i  (periph_req[ao_periph_pkg::POWER_MANAGER_IDX]),
    .reg_rsp_o  (periph_rsp[ao_periph_pkg::POWER_MANAGER_IDX]),
    .timer_irq_i(timer_irq),
    .core_sleep_i,
    .cpu_subsystem_powergate_switch_o,
    .cpu_subsystem_rst_no
  );

  assign rv_timer_irq_timer_o = timer_irq;

endmodule : ao_peripheral_subsystem

// File: sim/tb_ao_peripheral_subsystem.sv
// Testbench for the always-on peripheral subsystem
// Replays bus patterns from a file, checks responses and side outputs

module tb_ao_peripheral_subsystem;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int POLL_LIMIT      = 100;
  localparam int CYCLES_PER_LINE = 40;

  logic                     clk;
  logic                     rst_n;
  ao_periph_pkg::obi_req_t  slave_req;
  ao_periph_pkg::obi_resp_t slave_resp;
  logic                     boot_select;
  logic                     execute_from_flash;
  logic                     core_sleep;
  logic                     exit_valid;
  logic [31:0]              exit_value;
  logic                     powergate_switch;
  logic                     cpu_rst_n;
  logic                     timer_irq;

  int errors      = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  ao_peripheral_subsystem UUT (
    .clk_i                           (clk),
    .rst_n_i                         (rst_n),
    .slave_req_i                     (slave_req),
    .slave_resp_o                    (slave_resp),
    .boot_select_i                   (boot_select),
    .execute_from_flash_i            (execute_from_flash),
    .exit_valid_o                    (exit_valid),
    .exit_value_o                    (exit_value),
    .core_sleep_i                    (core_sleep),
    .cpu_subsystem_powergate_switch_o(powergate_switch),
    .cpu_subsystem_rst_no            (cpu_rst_n),
    .rv_timer_irq_timer_o            (timer_irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog sized from the pattern file length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d errors so far", cycle_count, errors);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] side_output(input logic [31:0] idx);
    case (idx)
      32'd0:   return {31'h0, exit_valid};
      32'd1:   return exit_value;
      32'd2:   return {31'h0, powergate_switch};
      32'd3:   return {31'h0, cpu_rst_n};
      32'd4:   return {31'h0, timer_irq};
      default: return 32'hdead_beef;
    endcase
  endfunction

  function automatic string side_name(input logic [31:0] idx);
    case (idx)
      32'd0:   return "exit_valid_o";
      32'd1:   return "exit_value_o";
      32'd2:   return "cpu_subsystem_powergate_switch_o";
      32'd3:   return "cpu_subsystem_rst_no";
      32'd4:   return "rv_timer_irq_timer_o";
      default: return "unknown output";
    endcase
  endfunction

  function automatic int count_lines(input int fd);
    int ch;
    int lines;
    lines = 0;
    ch = $fgetc(fd);
    while (ch != -1) begin
      if (ch == 10) begin
        lines++;
      end
      ch = $fgetc(fd);
    end
    return lines;
  endfunction

  task automatic skip_line(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got == exp) else begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Outputs right after reset release, before any bus traffic
  task automatic check_reset_values();
    check_word("rvalid", {31'h0, slave_resp.rvalid}, 32'h0);
    check_word("gnt", {31'h0, slave_resp.gnt}, 32'h0);
    check_word("exit_valid_o", {31'h0, exit_valid}, 32'h0);
    check_word("exit_value_o", exit_value, 32'h0);
    check_word("cpu_subsystem_powergate_switch_o", {31'h0, powergate_switch}, 32'h0);
    check_word("cpu_subsystem_rst_no", {31'h0, cpu_rst_n}, 32'h1);
    check_word("rv_timer_irq_timer_o", {31'h0, timer_irq}, 32'h0);
  endtask

  // Called on a falling edge, returns on the falling edge after the response
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    slave_req.req   = 1'b1;
    slave_req.we    = we;
    slave_req.be    = 4'hF;
    slave_req.addr  = addr;
    slave_req.wdata = wdata;
    #1;
    assert (slave_resp.gnt) else begin
      errors++;
      $display("request to %h at %0t was not granted", addr, $time);
    end
    @(negedge clk);
    slave_req.req = 1'b0;
    slave_req.we  = 1'b0;
    rdata = slave_resp.rdata;
    err   = slave_resp.err;
    assert (slave_resp.rvalid) else begin
      errors++;
      $display("no rvalid one cycle after request to %h at %0t", addr, $time);
    end
  endtask

  task automatic replay_patterns(input int fd);
    logic [7:0]  op_code;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic [31:0] exp_err;
    logic [31:0] rdata;
    logic        err;
    int          fields;
    int          polls;
    while ($fscanf(fd, "%s", op_code) == 1) begin
      if (op_code == "#") begin
        skip_line(fd);
      end else begin
        fields = $fscanf(fd, "%h %h %h %h", addr, wdata, exp_data, exp_err);
        if (fields != 4) begin
          errors++;
          $display("pattern line for op %s has %0d fields instead of 4", op_code, fields);
          skip_line(fd);
        end else begin
          case (op_code)
            "R", "W": begin
              bus_access(op_code == "W", addr, wdata, rdata, err);
              check_word("rdata", rdata, exp_data);
              check_word("err", {31'h0, err}, exp_err);
            end
            "G": begin
              bus_access(1'b0, addr, wdata, rdata, err);
              assert (rdata >= exp_data) else begin
                errors++;
                $display("mismatch at %0t: rdata got %h expected at least %h",
                         $time, rdata, exp_data);
              end
              check_word("err", {31'h0, err}, exp_err);
            end
            "P": begin
              polls = 0;
              bus_access(1'b0, addr, wdata, rdata, err);
              while ((rdata != exp_data || err != exp_err[0]) && polls < POLL_LIMIT) begin
                bus_access(1'b0, addr, wdata, rdata, err);
                polls++;
              end
              check_word("rdata", rdata, exp_data);
              check_word("err", {31'h0, err}, exp_err);
            end
            "O": begin
              polls = 0;
              while (side_output(addr) != exp_data && polls < POLL_LIMIT) begin
                @(negedge clk);
                polls++;
              end
              check_word(side_name(addr), side_output(addr), exp_data);
            end
            "S": begin
              boot_select        = wdata[0];
              execute_from_flash = wdata[1];
              core_sleep         = wdata[2];
              @(negedge clk);
            end
            default: begin
              errors++;
              $display("unknown pattern operation %s", op_code);
            end
          endcase
        end
      end
    end
  endtask

  initial begin
    int fd;
    int lines;
    slave_req          = '0;
    boot_select        = 1'b0;
    execute_from_flash = 1'b0;
    core_sleep         = 1'b0;
    rst_n              = 1'b0;
    fd = $fopen("sim/ao_bus_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open pattern file sim/ao_bus_patterns.txt");
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      lines = count_lines(fd);
      $fclose(fd);
      fd = $fopen("sim/ao_bus_patterns.txt", "r");
      cycle_limit = CYCLES_PER_LINE * lines + 10;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_reset_values();
      replay_patterns(fd);
      $fclose(fd);
      $display("%0d errors over %0d pattern lines", errors, lines);
      if (errors == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

endmodule : tb_ao_peripheral_subsystem

// File: sim/ao_bus_patterns.txt
# op addr wdata expected err, hex; S drives wdata bit0 boot_select, bit1 exec_flash, bit2 sleep
# P polls a read, G reads at least expected, O waits for output addr 0..4 (exit_valid..irq)
R 20001000 00000000 00000297 0
R 20001004 00000000 04028293 0
R 20001008 00000000 30529073 0
R 2000100C 00000000 20000337 0
R 20001010 00000000 00832383 0
R 20001014 00000000 00038663 0
R 20001018 00000000 10000437 0
R 2000101C 00000000 00040067 0
R 20001020 00000000 00000417 0
R 20001024 00000000 00042483 0
R 20001028 00000000 00048067 0
R 2000102C 00000000 10500073 0
R 20001030 00000000 ffdff06f 0
R 20001034 00000000 00000013 0
R 20001038 00000000 00000013 0
R 2000103C 00000000 00000013 0
R 20001040 00000000 00000000 1
# SoC control straps and exit
S 00000000 00000003 00000000 0
R 20000008 00000000 00000001 0
R 2000000C 00000000 00000001 0
S 00000000 00000001 00000000 0
R 2000000C 00000000 00000000 0
W 20000004 cafe0042 00000000 0
W 20000000 00000001 00000000 0
O 00000000 00000000 00000001 0
O 00000001 00000000 cafe0042 0
R 20000004 00000000 cafe0042 0
# Unmapped and unimplemented
R 30000000 00000000 00000000 1
W 20004000 12345678 00000000 1
R 20000010 00000000 00000000 1
R 20002010 00000000 00000000 1
R 20001004 00000000 04028293 0
# Timer
O 00000004 00000000 00000000 0
W 20002008 00000030 00000000 0
W 20002004 00000000 00000000 0
W 20002000 00000001 00000000 0
O 00000004 00000000 00000001 0
G 20002004 00000000 00000030 0
# Power manager sleep and wake
W 20003000 00000001 00000000 0
R 20003000 00000000 00000001 0
S 00000000 00000005 00000000 0
P 20003008 00000000 00000002 0
O 00000002 00000000 00000001 0
O 00000003 00000000 00000000 0
W 20003004 00000001 00000000 0
P 20003008 00000000 00000000 0
O 00000002 00000000 00000000 0
O 00000003 00000000 00000001 0
R 20003000 00000000 00000000 0
S 00000000 00000001 00000000 0

// File: sim.f
hdl/ao_periph_pkg.sv
hdl/obi_reg_bridge.sv
hdl/soc_ctrl.sv
hdl/boot_rom.sv
hdl/rv_timer.sv
hdl/power_manager.sv
hdl/ao_peripheral_subsystem.sv
sim/tb_ao_peripheral_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the always-on peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_ao_peripheral_subsystem
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module "$TOP" -f sim.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
  exit 0
fi
exit 1
